/* Bender.yml */
package:
  name: rdma_reg_ctrl

sources:
  - files:
      - rdma_ctrl_pkg.sv
      - cfg_writer.sv
      - rq_checker.sv
      - stat_reader.sv
      - axil_arbiter.sv
      - rdma_reg_ctrl.sv
  - target: test
    files:
      - tb_axil_slave.sv
      - tb_rdma_reg_ctrl.sv

/* axil_arbiter.sv */
/*
 * AXI-Lite master arbiter
 * Fixed-priority grant of three requesters onto independent write and read
 * channel state machines, with done routing and a sticky read error flag
 */
module axil_arbiter (
  input  logic                      axil_clk,
  input  logic                      axil_rstn,
  // Write requesters
  input  logic                      cfg_wr_req,
  input  rdma_ctrl_pkg::axil_addr_t cfg_wr_addr,
  input  rdma_ctrl_pkg::axil_data_t cfg_wr_data,
  output logic                      cfg_wr_done,
  input  logic                      rq_wr_req,
  input  rdma_ctrl_pkg::axil_addr_t rq_wr_addr,
  input  rdma_ctrl_pkg::axil_data_t rq_wr_data,
  output logic                      rq_wr_done,
  // Read requesters
  input  logic                      stat_rd_req,
  input  rdma_ctrl_pkg::axil_addr_t stat_rd_addr,
  output logic                      stat_rd_done,
  input  logic                      rq_rd_req,
  input  rdma_ctrl_pkg::axil_addr_t rq_rd_addr,
  output logic                      rq_rd_done,
  output rdma_ctrl_pkg::axil_data_t rd_data,
  output logic                      bus_err,
  // AXI-Lite master
  output logic                      awvalid,
  output rdma_ctrl_pkg::axil_addr_t awaddr,
  input  logic                      awready,
  output logic                      wvalid,
  output rdma_ctrl_pkg::axil_data_t wdata,
  input  logic                      wready,
  input  logic                      bvalid,
  input  rdma_ctrl_pkg::axil_resp_t bresp,
  output logic                      bready,
  output logic                      arvalid,
  output rdma_ctrl_pkg::axil_addr_t araddr,
  input  logic                      arready,
  input  logic                      rvalid,
  input  rdma_ctrl_pkg::axil_data_t rdata,
  input  rdma_ctrl_pkg::axil_resp_t rresp,
  output logic                      rready
);

  import rdma_ctrl_pkg::*;

  wr_state_t wr_state;
  rd_state_t rd_state;
  logic      wr_gnt_cfg;
  logic      rd_gnt_stat;
  logic      wr_fin;
  logic      rd_fin;

  // ==========================================================================
  // Write channel
  // ==========================================================================
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      wr_state   <= wr_idle;
      wr_gnt_cfg <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle: begin
          // Configuration writer has priority
          if (cfg_wr_req || rq_wr_req) begin
            wr_gnt_cfg <= cfg_wr_req;
            wr_state   <= wr_addr;
          end
        end
        wr_addr: if (awready) wr_state <= wr_data;
        wr_data: if (wready) wr_state <= wr_resp;
        wr_resp: if (bvalid) wr_state <= wr_idle;
        default: wr_state <= wr_idle;
      endcase
    end
  end

  assign awvalid = (wr_state == wr_addr);
  assign awaddr  = wr_gnt_cfg ? cfg_wr_addr : rq_wr_addr;
  assign wvalid  = (wr_state == wr_data);
  assign wdata   = wr_gnt_cfg ? cfg_wr_data : rq_wr_data;
  assign bready  = (wr_state == wr_resp);

  // bresp is taken but not checked
  assign wr_fin      = bready && bvalid;
  assign cfg_wr_done = wr_fin && wr_gnt_cfg;
  assign rq_wr_done  = wr_fin && !wr_gnt_cfg;

  // ==========================================================================
  // Read channel
  // ==========================================================================
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      rd_state    <= rd_idle;
      rd_gnt_stat <= 1'b0;
      bus_err     <= 1'b0;
    end else begin
      case (rd_state)
        rd_idle: begin
          // Statistics reader has priority
          if (stat_rd_req || rq_rd_req) begin
            rd_gnt_stat <= stat_rd_req;
            rd_state    <= rd_addr;
          end
        end
        rd_addr: if (arready) rd_state <= rd_resp;
        rd_resp: begin
          if (rvalid) begin
            rd_state <= rd_idle;
            if (rresp != AXIL_RESP_OKAY) begin
              bus_err <= 1'b1;
            end
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  assign arvalid = (rd_state == rd_addr);
  assign araddr  = rd_gnt_stat ? stat_rd_addr : rq_rd_addr;
  assign rready  = (rd_state == rd_resp);

  assign rd_fin       = rready && rvalid;
  assign stat_rd_done = rd_fin && rd_gnt_stat;
  assign rq_rd_done   = rd_fin && !rd_gnt_stat;
  assign rd_data      = rdata;

endmodule

/* cfg_writer.sv */
/*
 * Configuration register writer
 * Holds one address/data entry and keeps a write request up until it completes
 */
module cfg_writer (
  input  logic                      axil_clk,
  input  logic                      axil_rstn,
  input  logic                      cfg_load,
  input  rdma_ctrl_pkg::axil_addr_t cfg_addr,
  input  rdma_ctrl_pkg::axil_data_t cfg_data,
  output logic                      cfg_busy,
  output logic                      cfg_done,
  output logic                      cfg_wr_req,
  output rdma_ctrl_pkg::axil_addr_t cfg_wr_addr,
  output rdma_ctrl_pkg::axil_data_t cfg_wr_data,
  input  logic                      cfg_wr_done
);

  logic busy;
  logic take;

  // Loads while an entry is pending are dropped
  assign take = cfg_load && !busy;

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      busy     <= 1'b0;
      cfg_done <= 1'b0;
    end else begin
      cfg_done <= 1'b0;
      if (take) begin
        busy <= 1'b1;
      end else if (busy && cfg_wr_done) begin
        busy     <= 1'b0;
        cfg_done <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge axil_clk) begin
    if (take) begin
      cfg_wr_addr <= cfg_addr;
      cfg_wr_data <= cfg_data;
    end
  end

  assign cfg_busy   = busy;
  assign cfg_wr_req = busy;

endmodule

/* filelist.f */
rdma_ctrl_pkg.sv
cfg_writer.sv
rq_checker.sv
stat_reader.sv
axil_arbiter.sv
rdma_reg_ctrl.sv
tb_axil_slave.sv
tb_rdma_reg_ctrl.sv

/* rdma_ctrl_pkg.sv */
/*
 * RDMA register controller definitions
 * AXI-Lite widths, doorbell marker, poll limit and FSM encodings
 */
package rdma_ctrl_pkg;

  // ==========================================================================
  // AXI-Lite bus
  // ==========================================================================
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

  // ==========================================================================
  // Receive-queue doorbells
  // ==========================================================================
  // Golden value that turns an entry into a consumer doorbell write
  localparam axil_data_t DB_WRITE_MARK = 32'hffff_ffff;

  // Completed producer doorbell reads before giving up
  localparam int unsigned POLL_LIMIT = 1024;

  typedef logic [10:0] poll_cnt_t;

  // ==========================================================================
  // State machines
  // ==========================================================================
  typedef enum logic [1:0] {
    wr_idle,
    wr_addr,
    wr_data,
    wr_resp
  } wr_state_t;

  typedef enum logic [1:0] {
    rd_idle,
    rd_addr,
    rd_resp
  } rd_state_t;

  typedef enum logic [1:0] {
    rq_idle,
    rq_read,
    rq_write,
    rq_done_st
  } rq_state_t;

endpackage

/* rdma_reg_ctrl.sv */
/*
 * RDMA AXI-Lite register access controller
 * Configuration writer, receive-queue checker and statistics reader sharing
 * one AXI-Lite master port
 */
module rdma_reg_ctrl (
  input  logic                      axil_clk,
  input  logic                      axil_rstn,
  input  logic                      cfg_load,
  input  rdma_ctrl_pkg::axil_addr_t cfg_addr,
  input  rdma_ctrl_pkg::axil_data_t cfg_data,
  output logic                      cfg_busy,
  output logic                      cfg_done,
  input  logic                      rq_load,
  input  rdma_ctrl_pkg::axil_addr_t rq_addr,
  input  rdma_ctrl_pkg::axil_data_t rq_golden,
  output logic                      rq_busy,
  output logic                      rq_done,
  output logic                      rq_timeout,
  input  logic                      stat_load,
  input  rdma_ctrl_pkg::axil_addr_t stat_addr,
  output logic                      stat_busy,
  output logic                      stat_valid,
  output rdma_ctrl_pkg::axil_data_t stat_value,
  output logic                      bus_err,
  // AXI-Lite master
  output logic                      awvalid,
  output rdma_ctrl_pkg::axil_addr_t awaddr,
  input  logic                      awready,
  output logic                      wvalid,
  output rdma_ctrl_pkg::axil_data_t wdata,
  input  logic                      wready,
  input  logic                      bvalid,
  input  rdma_ctrl_pkg::axil_resp_t bresp,
  output logic                      bready,
  output logic                      arvalid,
  output rdma_ctrl_pkg::axil_addr_t araddr,
  input  logic                      arready,
  input  logic                      rvalid,
  input  rdma_ctrl_pkg::axil_data_t rdata,
  input  rdma_ctrl_pkg::axil_resp_t rresp,
  output logic                      rready
);

  import rdma_ctrl_pkg::*;

  logic       cfg_wr_req;
  axil_addr_t cfg_wr_addr;
  axil_data_t cfg_wr_data;
  logic       cfg_wr_done;
  logic       rq_wr_req;
  axil_addr_t rq_wr_addr;
  axil_data_t rq_wr_data;
  logic       rq_wr_done;
  logic       rq_rd_req;
  axil_addr_t rq_rd_addr;
  logic       rq_rd_done;
  logic       stat_rd_req;
  axil_addr_t stat_rd_addr;
  logic       stat_rd_done;
  axil_data_t rd_data;

  cfg_writer u_cfg_writer (
    .axil_clk    (axil_clk),
    .axil_rstn   (axil_rstn),
    .cfg_load    (cfg_load),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .cfg_busy    (cfg_busy),
    .cfg_done    (cfg_done),
    .cfg_wr_req  (cfg_wr_req),
    .cfg_wr_addr (cfg_wr_addr),
    .cfg_wr_data (cfg_wr_data),
    .cfg_wr_done (cfg_wr_done)
  );

  rq_checker u_rq_checker (
    .axil_clk   (axil_clk),
    .axil_rstn  (axil_rstn),
    .rq_load    (rq_load),
    .rq_addr    (rq_addr),
    .rq_golden  (rq_golden),
    .rq_busy    (rq_busy),
    .rq_done    (rq_done),
    .rq_timeout (rq_timeout),
    .rq_rd_req  (rq_rd_req),
    .rq_rd_addr (rq_rd_addr),
    .rq_rd_done (rq_rd_done),
    .rd_data    (rd_data),
    .rq_wr_req  (rq_wr_req),
    .rq_wr_addr (rq_wr_addr),
    .rq_wr_data (rq_wr_data),
    .rq_wr_done (rq_wr_done)
  );

  stat_reader u_stat_reader (
    .axil_clk     (axil_clk),
    .axil_rstn    (axil_rstn),
    .stat_load    (stat_load),
    .stat_addr    (stat_addr),
    .stat_busy    (stat_busy),
    .stat_valid   (stat_valid),
    .stat_value   (stat_value),
    .stat_rd_req  (stat_rd_req),
    .stat_rd_addr (stat_rd_addr),
    .stat_rd_done (stat_rd_done),
    .rd_data      (rd_data)
  );

  axil_arbiter u_axil_arbiter (
    .axil_clk     (axil_clk),
    .axil_rstn    (axil_rstn),
    .cfg_wr_req   (cfg_wr_req),
    .cfg_wr_addr  (cfg_wr_addr),
    .cfg_wr_data  (cfg_wr_data),
    .cfg_wr_done  (cfg_wr_done),
    .rq_wr_req    (rq_wr_req),
    .rq_wr_addr   (rq_wr_addr),
    .rq_wr_data   (rq_wr_data),
    .rq_wr_done   (rq_wr_done),
    .stat_rd_req  (stat_rd_req),
    .stat_rd_addr (stat_rd_addr),
    .stat_rd_done (stat_rd_done),
    .rq_rd_req    (rq_rd_req),
    .rq_rd_addr   (rq_rd_addr),
    .rq_rd_done   (rq_rd_done),
    .rd_data      (rd_data),
    .bus_err      (bus_err),
    .awvalid      (awvalid),
    .awaddr       (awaddr),
    .awready      (awready),
    .wvalid       (wvalid),
    .wdata        (wdata),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .bready       (bready),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rresp        (rresp),
    .rready       (rready)
  );

endmodule

/* rq_checker.sv */
/*
 * Receive-queue completion checker
 * Polls the producer doorbell until it matches the golden value or times out,
 * or writes the last doorbell value back to the consumer doorbell
 */
module rq_checker (
  input  logic                      axil_clk,
  input  logic                      axil_rstn,
  input  logic                      rq_load,
  input  rdma_ctrl_pkg::axil_addr_t rq_addr,
  input  rdma_ctrl_pkg::axil_data_t rq_golden,
  output logic                      rq_busy,
  output logic                      rq_done,
  output logic                      rq_timeout,
  output logic                      rq_rd_req,
  output rdma_ctrl_pkg::axil_addr_t rq_rd_addr,
  input  logic                      rq_rd_done,
  input  rdma_ctrl_pkg::axil_data_t rd_data,
  output logic                      rq_wr_req,
  output rdma_ctrl_pkg::axil_addr_t rq_wr_addr,
  output rdma_ctrl_pkg::axil_data_t rq_wr_data,
  input  logic                      rq_wr_done
);

  import rdma_ctrl_pkg::*;

  rq_state_t  state;
  axil_addr_t addr_q;
  axil_data_t golden_q;
  axil_data_t last_db;
  poll_cnt_t  poll_cnt;
  logic       take;

  assign take = rq_load && !rq_busy;

  // ==========================================================================
  // Entry sequencing
  // ==========================================================================
  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      state      <= rq_idle;
      poll_cnt   <= '0;
      last_db    <= '0;
      rq_timeout <= 1'b0;
    end else begin
      case (state)
        rq_idle, rq_done_st: begin
          state <= rq_idle;
          if (take) begin
            poll_cnt <= '0;
            state    <= (rq_golden == DB_WRITE_MARK) ? rq_write : rq_read;
          end
        end
        rq_read: begin
          // Request stays up between polls so the arbiter reissues it
          if (rq_rd_done) begin
            last_db  <= rd_data;
            poll_cnt <= poll_cnt + 1'b1;
            if (rd_data == golden_q) begin
              state <= rq_done_st;
            end else if (poll_cnt == poll_cnt_t'(POLL_LIMIT - 1)) begin
              rq_timeout <= 1'b1;
              state      <= rq_done_st;
            end
          end
        end
        rq_write: begin
          if (rq_wr_done) begin
            state <= rq_done_st;
          end
        end
        default: begin
          state <= rq_idle;
        end
      endcase
    end
  end

  // Entry payload
  always_ff @(posedge axil_clk) begin
    if (take) begin
      addr_q   <= rq_addr;
      golden_q <= rq_golden;
    end
  end

  // ==========================================================================
  // Outputs
  // ==========================================================================
  assign rq_busy    = (state == rq_read) || (state == rq_write);
  assign rq_done    = (state == rq_done_st);
  assign rq_rd_req  = (state == rq_read);
  assign rq_rd_addr = addr_q;
  assign rq_wr_req  = (state == rq_write);
  assign rq_wr_addr = addr_q;
  // Consumer doorbell gets the last producer value seen
  assign rq_wr_data = last_db;

endmodule

/* stat_reader.sv */
/*
 * Statistics register reader
 * Requests one bus read per entry and returns the word with a valid pulse
 */
module stat_reader (
  input  logic                      axil_clk,
  input  logic                      axil_rstn,
  input  logic                      stat_load,
  input  rdma_ctrl_pkg::axil_addr_t stat_addr,
  output logic                      stat_busy,
  output logic                      stat_valid,
  output rdma_ctrl_pkg::axil_data_t stat_value,
  output logic                      stat_rd_req,
  output rdma_ctrl_pkg::axil_addr_t stat_rd_addr,
  input  logic                      stat_rd_done,
  input  rdma_ctrl_pkg::axil_data_t rd_data
);

  logic busy;
  logic take;

  assign take = stat_load && !busy;

  always_ff @(posedge axil_clk) begin
    if (!axil_rstn) begin
      busy       <= 1'b0;
      stat_valid <= 1'b0;
    end else begin
      stat_valid <= 1'b0;
      if (take) begin
        busy <= 1'b1;
      end else if (busy && stat_rd_done) begin
        busy       <= 1'b0;
        stat_valid <= 1'b1;
      end
    end
  end

  // Address held for the request, read word held for the consumer
  always_ff @(posedge axil_clk) begin
    if (take) begin
      stat_rd_addr <= stat_addr;
    end
    if (busy && stat_rd_done) begin
      stat_value <= rd_data;
    end
  end

  assign stat_busy   = busy;
  assign stat_rd_req = busy;

endmodule

/* tb_axil_slave.sv */
/*
 * AXI-Lite slave register model for the testbench
 * Sixteen words, a counting producer doorbell at 0x40, error space from 0x80
 * and random ready and valid delays of 0 to 3 cycles
 */
module tb_axil_slave (
  input  logic                      axil_clk,
  input  logic                      axil_rstn,
  input  logic                      awvalid,
  input  rdma_ctrl_pkg::axil_addr_t awaddr,
  output logic                      awready,
  input  logic                      wvalid,
  input  rdma_ctrl_pkg::axil_data_t wdata,
  output logic                      wready,
  output logic                      bvalid,
  output rdma_ctrl_pkg::axil_resp_t bresp,
  input  logic                      bready,
  input  logic                      arvalid,
  input  rdma_ctrl_pkg::axil_addr_t araddr,
  output logic                      arready,
  output logic                      rvalid,
  output rdma_ctrl_pkg::axil_data_t rdata,
  output rdma_ctrl_pkg::axil_resp_t rresp,
  input  logic                      rready
);

  import rdma_ctrl_pkg::*;

  localparam axil_addr_t DB_ADDR     = 32'h0000_0040;
  localparam axil_addr_t ERR_BASE    = 32'h0000_0080;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  axil_data_t mem [16];
  axil_data_t db_count;
  axil_addr_t aw_q;
  axil_addr_t ar_q;
  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic [1:0] b_wait;
  logic [1:0] ar_wait;
  logic [1:0] r_wait;
  logic       b_pend;
  logic       r_pend;
  integer     seed;

  initial begin
    seed    = 32'h7af;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = AXIL_RESP_OKAY;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = AXIL_RESP_OKAY;
  end

  function automatic logic [1:0] pick_delay();
    logic [31:0] r;
    r = $random(seed);
    return r[1:0];
  endfunction

  // ==========================================================================
  // Write channel
  // ==========================================================================
  always @(posedge axil_clk) begin
    if (!axil_rstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= AXIL_RESP_OKAY;
      b_pend  <= 1'b0;
      aw_wait <= pick_delay();
      w_wait  <= pick_delay();
      b_wait  <= 2'd0;
      aw_q    <= '0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_q    <= awaddr;
        aw_wait <= pick_delay();
      end else if (awvalid) begin
        if (aw_wait == 2'd0) begin
          awready <= 1'b1;
        end else begin
          aw_wait <= aw_wait - 1'b1;
        end
      end
      if (wvalid && wready) begin
        wready          <= 1'b0;
        mem[aw_q[5:2]]  <= wdata;
        w_wait          <= pick_delay();
        b_pend          <= 1'b1;
        b_wait          <= pick_delay();
      end else if (wvalid) begin
        if (w_wait == 2'd0) begin
          wready <= 1'b1;
        end else begin
          w_wait <= w_wait - 1'b1;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (b_pend) begin
        if (b_wait == 2'd0) begin
          bvalid <= 1'b1;
          b_pend <= 1'b0;
        end else begin
          b_wait <= b_wait - 1'b1;
        end
      end
    end
  end

  // ==========================================================================
  // Read channel
  // ==========================================================================
  always @(posedge axil_clk) begin
    if (!axil_rstn) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rdata    <= '0;
      rresp    <= AXIL_RESP_OKAY;
      r_pend   <= 1'b0;
      ar_wait  <= pick_delay();
      r_wait   <= 2'd0;
      ar_q     <= '0;
      db_count <= '0;
    end else begin
      if (arvalid && arready) begin
        arready <= 1'b0;
        ar_q    <= araddr;
        ar_wait <= pick_delay();
        r_pend  <= 1'b1;
        r_wait  <= pick_delay();
      end else if (arvalid) begin
        if (ar_wait == 2'd0) begin
          arready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 1'b1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (r_pend) begin
        if (r_wait == 2'd0) begin
          rvalid <= 1'b1;
          r_pend <= 1'b0;
          if (ar_q >= ERR_BASE) begin
            rdata <= '0;
            rresp <= RESP_SLVERR;
          end else if (ar_q == DB_ADDR) begin
            // Producer doorbell advances on every read
            rdata    <= db_count;
            rresp    <= AXIL_RESP_OKAY;
            db_count <= db_count + 1'b1;
          end else begin
            rdata <= mem[ar_q[5:2]];
            rresp <= AXIL_RESP_OKAY;
          end
        end else begin
          r_wait <= r_wait - 1'b1;
        end
      end
    end
  end

endmodule

/* tb_rdma_reg_ctrl.sv */
/*
 * Testbench for the RDMA register access controller
 * Runs a table of configuration, doorbell and statistics entries against
 * an AXI-Lite register model and checks each completion
 */
module tb_rdma_reg_ctrl;

  import rdma_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int IO_SKEW      = 10;
  localparam int RESET_CYCLES = 3;
  localparam int ENTRY_CYCLES = 100;
  localparam int READ_CYCLES  = 10;

  // Producer doorbell value the first poll waits for
  localparam axil_data_t POLL_GOLDEN = 32'd5;

  typedef enum logic [1:0] {
    k_cfg,
    k_rq,
    k_stat,
    k_both
  } entry_kind_t;

  typedef struct packed {
    entry_kind_t kind;
    axil_addr_t  addr;
    axil_data_t  value;
    axil_addr_t  read_addr;
    axil_data_t  exp_data;
    logic        exp_timeout;
    logic        exp_err;
  } entry_t;

  logic       axil_clk;
  logic       axil_rstn;
  logic       cfg_load;
  axil_addr_t cfg_addr;
  axil_data_t cfg_data;
  logic       cfg_busy;
  logic       cfg_done;
  logic       rq_load;
  axil_addr_t rq_addr;
  axil_data_t rq_golden;
  logic       rq_busy;
  logic       rq_done;
  logic       rq_timeout;
  logic       stat_load;
  axil_addr_t stat_addr;
  logic       stat_busy;
  logic       stat_valid;
  axil_data_t stat_value;
  logic       bus_err;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  axil_data_t wdata;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rready;

  entry_t entries[$];
  logic   table_ready = 1'b0;

  rdma_reg_ctrl u_rdma_reg_ctrl (.*);

  tb_axil_slave u_axil_slave (.*);

  always #(CLK_PERIOD / 2) axil_clk = ~axil_clk;

  // ==========================================================================
  // Checks
  // ==========================================================================
  task automatic stop_on_failure();
    $display("Finished with errors");
    $fatal(1, "Run stopped after a failed check");
  endtask

  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // ==========================================================================
  // Entry handling
  // ==========================================================================
  task automatic add_entry(input entry_kind_t kind, input axil_addr_t addr,
                           input axil_data_t value, input axil_addr_t read_addr,
                           input axil_data_t exp_data, input logic exp_timeout,
                           input logic exp_err);
    entry_t e;
    e.kind        = kind;
    e.addr        = addr;
    e.value       = value;
    e.read_addr   = read_addr;
    e.exp_data    = exp_data;
    e.exp_timeout = exp_timeout;
    e.exp_err     = exp_err;
    entries.push_back(e);
  endtask

  task automatic build_table();
    add_entry(k_cfg,  32'h04, 32'h1111_aaaa, '0, '0, 1'b0, 1'b0);
    add_entry(k_stat, 32'h04, '0, '0, 32'h1111_aaaa, 1'b0, 1'b0);
    add_entry(k_cfg,  32'h08, 32'hdead_beef, '0, '0, 1'b0, 1'b0);
    add_entry(k_stat, 32'h08, '0, '0, 32'hdead_beef, 1'b0, 1'b0);
    add_entry(k_cfg,  32'h3c, 32'h0bad_f00d, '0, '0, 1'b0, 1'b0);
    add_entry(k_stat, 32'h3c, '0, '0, 32'h0bad_f00d, 1'b0, 1'b0);
    // Counter reads 0 through 5 before the match
    add_entry(k_rq,   32'h40, POLL_GOLDEN, '0, '0, 1'b0, 1'b0);
    add_entry(k_stat, 32'h40, '0, '0, POLL_GOLDEN + 1, 1'b0, 1'b0);
    // Consumer doorbell gets the last value polled
    add_entry(k_rq,   32'h10, DB_WRITE_MARK, '0, '0, 1'b0, 1'b0);
    add_entry(k_stat, 32'h10, '0, '0, POLL_GOLDEN, 1'b0, 1'b0);
    // Golden already passed, so every poll misses
    add_entry(k_rq,   32'h40, 32'd3, '0, '0, 1'b1, 1'b0);
    add_entry(k_stat, 32'h40, '0, '0, axil_data_t'(POLL_GOLDEN + 1 + POLL_LIMIT + 1),
              1'b1, 1'b0);
    add_entry(k_stat, 32'h80, '0, '0, 32'h0, 1'b1, 1'b1);
    add_entry(k_both, 32'h08, 32'h5555_0000, 32'h04, 32'h1111_aaaa, 1'b1, 1'b1);
    add_entry(k_stat, 32'h08, '0, '0, 32'h5555_0000, 1'b1, 1'b1);
  endtask

  task automatic wait_cfg_done();
    do begin
      @(posedge axil_clk);
      #IO_SKEW;
    end while (!cfg_done);
    check_flag("cfg_busy", cfg_busy, 1'b0);
  endtask

  task automatic wait_rq_done();
    do begin
      @(posedge axil_clk);
      #IO_SKEW;
    end while (!rq_done);
    check_flag("rq_busy", rq_busy, 1'b0);
  endtask

  task automatic wait_stat_valid(input axil_data_t exp_value);
    do begin
      @(posedge axil_clk);
      #IO_SKEW;
    end while (!stat_valid);
    check_flag("stat_busy", stat_busy, 1'b0);
    check_data("stat_value", stat_value, exp_value);
  endtask

  task automatic apply_entry(input entry_t e);
    @(posedge axil_clk);
    #IO_SKEW;
    if (e.kind == k_cfg || e.kind == k_both) begin
      check_flag("cfg_busy", cfg_busy, 1'b0);
      cfg_load = 1'b1;
      cfg_addr = e.addr;
      cfg_data = e.value;
    end
    if (e.kind == k_rq) begin
      check_flag("rq_busy", rq_busy, 1'b0);
      rq_load   = 1'b1;
      rq_addr   = e.addr;
      rq_golden = e.value;
    end
    if (e.kind == k_stat || e.kind == k_both) begin
      check_flag("stat_busy", stat_busy, 1'b0);
      stat_load = 1'b1;
      stat_addr = (e.kind == k_both) ? e.read_addr : e.addr;
    end
    @(posedge axil_clk);
    #IO_SKEW;
    cfg_load  = 1'b0;
    rq_load   = 1'b0;
    stat_load = 1'b0;
    case (e.kind)
      k_cfg: begin
        check_flag("cfg_busy", cfg_busy, 1'b1);
        wait_cfg_done();
      end
      k_rq: begin
        check_flag("rq_busy", rq_busy, 1'b1);
        wait_rq_done();
      end
      k_stat: begin
        check_flag("stat_busy", stat_busy, 1'b1);
        wait_stat_valid(e.exp_data);
      end
      default: begin
        check_flag("cfg_busy", cfg_busy, 1'b1);
        check_flag("stat_busy", stat_busy, 1'b1);
        fork
          wait_cfg_done();
          wait_stat_valid(e.exp_data);
        join
      end
    endcase
    // Timeout and bus error flags are sticky across later entries
    check_flag("rq_timeout", rq_timeout, e.exp_timeout);
    check_flag("bus_err", bus_err, e.exp_err);
  endtask

  // ==========================================================================
  // Main sequence and watchdog
  // ==========================================================================
  initial begin
    axil_clk  = 1'b0;
    axil_rstn = 1'b0;
    cfg_load  = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    rq_load   = 1'b0;
    rq_addr   = '0;
    rq_golden = '0;
    stat_load = 1'b0;
    stat_addr = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge axil_clk);
    #IO_SKEW;
    axil_rstn = 1'b1;
    check_flag("awvalid", awvalid, 1'b0);
    check_flag("wvalid", wvalid, 1'b0);
    check_flag("bready", bready, 1'b0);
    check_flag("arvalid", arvalid, 1'b0);
    check_flag("rready", rready, 1'b0);
    check_flag("cfg_busy", cfg_busy, 1'b0);
    check_flag("cfg_done", cfg_done, 1'b0);
    check_flag("rq_busy", rq_busy, 1'b0);
    check_flag("rq_done", rq_done, 1'b0);
    check_flag("rq_timeout", rq_timeout, 1'b0);
    check_flag("stat_busy", stat_busy, 1'b0);
    check_flag("stat_valid", stat_valid, 1'b0);
    check_flag("bus_err", bus_err, 1'b0);
    for (int i = 0; i < entries.size(); i++) begin
      apply_entry(entries[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    int unsigned limit;
    wait (table_ready);
    limit = RESET_CYCLES + entries.size() * ENTRY_CYCLES + POLL_LIMIT * READ_CYCLES;
    repeat (limit) @(posedge axil_clk);
    $display("Watchdog expired after %0d cycles before all entries completed", limit);
    stop_on_failure();
  end

endmodule
